// File: dv/tb_ip_arb_mux.sv
/* Arbitrated IP mux testbench */

`timescale 1ns/100ps
`default_nettype none

module tb_ip_arb_mux;

    localparam int NSRC       = arb_mux_pkg::S_COUNT;
    localparam int MAX_FRAMES = 32;
    localparam int MAX_BEATS  = 16;
    localparam int PER_SRC    = 3;

    logic                            clk = 1'b0;
    logic                            rst;
    arb_mux_pkg::port_mask_t         s_hdr_valid;
    wire arb_mux_pkg::port_mask_t    s_hdr_ready;
    eth_hdr_pkg::ip_hdr_t            s_hdr [NSRC];
    arb_mux_pkg::payload_beat_t      s_payload [NSRC];
    arb_mux_pkg::port_mask_t         s_payload_valid;
    wire arb_mux_pkg::port_mask_t    s_payload_ready;
    wire                             m_hdr_valid;
    logic                            m_hdr_ready;
    wire eth_hdr_pkg::ip_hdr_t       m_hdr;
    wire arb_mux_pkg::payload_beat_t m_payload;
    wire                             m_payload_valid;
    logic                            m_payload_ready;

    // generated frames and the per-source queues that offer them
    eth_hdr_pkg::ip_hdr_t       frame_hdr  [MAX_FRAMES];
    int                         frame_len  [MAX_FRAMES];
    arb_mux_pkg::payload_beat_t frame_beat [MAX_FRAMES][MAX_BEATS];
    int                         frame_count;
    int                         src_frame  [NSRC][MAX_FRAMES];
    int                         src_count  [NSRC];
    int                         src_seq    [NSRC];
    int                         hdr_ptr    [NSRC];
    int                         pay_ptr    [NSRC];
    int                         beat_ptr   [NSRC];

    // expected output order, as frame numbers
    int exp_order [$];
    int last_served;
    int hdr_idx;
    int beat_frm;
    int beat_idx;

    logic                 src_run;
    logic                 pay_stall;
    logic                 hdr_stall;
    logic                 order_check;
    logic                 timed_out;
    logic                 hdr_wait;
    eth_hdr_pkg::ip_hdr_t hdr_held;
    logic                 hdr_level;
    int                   hdr_stretch;
    logic [31:0]          rng_state = 32'd56340;

    int test_errors;
    int order_errors;
    int total_errors;
    int tests_run;
    int tests_failed;

    ip_arb_mux DUT (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_hdr           (s_hdr),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_hdr           (m_hdr),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // round robin: walk upward from the last served source, wrapping
    function automatic void build_expected_order();
        int taken [NSRC];
        int remaining;
        int idx;
        remaining = 0;
        for (int i = 0; i < NSRC; i++) begin
            taken[i] = 0;
            remaining += src_count[i];
        end
        exp_order.delete();
        idx = last_served;
        while (remaining > 0) begin
            idx = (idx + 1) % NSRC;
            if (taken[idx] < src_count[idx]) begin
                exp_order.push_back(src_frame[idx][taken[idx]]);
                taken[idx]++;
                remaining--;
                last_served = idx;
            end
        end
    endfunction

    task automatic check_hdr(input string name, input eth_hdr_pkg::ip_hdr_t exp,
                             input eth_hdr_pkg::ip_hdr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic check_beat(input string name, input arb_mux_pkg::payload_beat_t exp,
                              input arb_mux_pkg::payload_beat_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic check_mask(input string name, input arb_mux_pkg::port_mask_t exp,
                              input arb_mux_pkg::port_mask_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic check_idle();
        check_mask("s_hdr_ready", '0, s_hdr_ready);
        check_mask("s_payload_ready", '0, s_payload_ready);
        check_flag("m_hdr_valid", 1'b0, m_hdr_valid);
        check_flag("m_payload_valid", 1'b0, m_payload_valid);
    endtask

    // header fields carry the source index and its sequence number
    task automatic add_frame(input int src);
        int          f;
        int          len;
        logic [31:0] r;
        f = frame_count;
        r = rand_next();
        len = 1 + int'(r[3:0]);
        frame_len[f] = len;
        frame_hdr[f] = '0;
        frame_hdr[f].eth_dest_mac = 48'h02_00_00_00_00_01;
        frame_hdr[f].eth_src_mac = 48'h02_00_00_00_10_00 | eth_hdr_pkg::mac_addr_t'(src);
        frame_hdr[f].eth_type = 16'h0800;
        frame_hdr[f].version = 4'd4;
        frame_hdr[f].ihl = 4'd5;
        frame_hdr[f].length = eth_hdr_pkg::ip_len_t'(20 + len);
        frame_hdr[f].identification = eth_hdr_pkg::ip_len_t'(src_seq[src]);
        frame_hdr[f].header_checksum = r[31:16];
        frame_hdr[f].ttl = 8'd64;
        frame_hdr[f].protocol = 8'h11;
        frame_hdr[f].source_ip = 32'h0a00_0000 | eth_hdr_pkg::ip_addr_t'(src);
        frame_hdr[f].dest_ip = rand_next();
        for (int b = 0; b < len; b++) begin
            r = rand_next();
            frame_beat[f][b].data = r[7:0];
            frame_beat[f][b].last = (b == len - 1);
            frame_beat[f][b].user = r[8] & r[9];
        end
        src_frame[src][src_count[src]] = f;
        src_count[src]++;
        src_seq[src]++;
        frame_count++;
    endtask

    task automatic start_test();
        test_errors = 0;
        order_errors = 0;
        frame_count = 0;
        for (int i = 0; i < NSRC; i++) begin
            src_count[i] = 0;
            hdr_ptr[i] = 0;
            pay_ptr[i] = 0;
            beat_ptr[i] = 0;
        end
    endtask

    task automatic fill_all_sources();
        for (int k = 0; k < PER_SRC; k++) begin
            for (int s = 0; s < NSRC; s++) begin
                add_frame(s);
            end
        end
    endtask

    task automatic run_frames(input logic pay_stall_en, input logic hdr_stall_en,
                              input logic order_en);
        int total_beats;
        int limit;
        int cycles;
        if (timed_out) begin
            return;
        end
        total_beats = 0;
        for (int k = 0; k < frame_count; k++) begin
            total_beats += frame_len[k];
        end
        limit = 4 * total_beats + 50 * frame_count;
        build_expected_order();
        hdr_idx = 0;
        beat_frm = 0;
        beat_idx = 0;
        pay_stall = pay_stall_en;
        hdr_stall = hdr_stall_en;
        order_check = order_en;
        src_run = 1'b1;
        cycles = 0;
        while ((hdr_idx != exp_order.size() || beat_frm != exp_order.size()) &&
               cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        pay_stall = 1'b0;
        hdr_stall = 1'b0;
        if (hdr_idx != exp_order.size() || beat_frm != exp_order.size()) begin
            $display("ERROR: run timed out after %0d cycles, %0d of %0d frames finished",
                     cycles, beat_frm, exp_order.size());
            timed_out = 1'b1;
            test_errors++;
            total_errors++;
        end
        repeat (4) @(negedge clk);
        src_run = 1'b0;
        order_check = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        tests_run++;
        if (errs != 0 || timed_out) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", num, name, errs);
        end else begin
            $display("test %0d %s: passed", num, name);
        end
    endtask

    // source drivers; pointers follow the handshakes seen on this edge
    always @(posedge clk) begin : drive_sources
        if (src_run) begin
            for (int i = 0; i < NSRC; i++) begin
                if (s_hdr_valid[i] && s_hdr_ready[i]) begin
                    hdr_ptr[i]++;
                end
                if (s_payload_valid[i] && s_payload_ready[i]) begin
                    beat_ptr[i]++;
                    if (beat_ptr[i] == frame_len[src_frame[i][pay_ptr[i]]]) begin
                        beat_ptr[i] = 0;
                        pay_ptr[i]++;
                    end
                end
                if (hdr_ptr[i] == pay_ptr[i] && hdr_ptr[i] < src_count[i]) begin
                    s_hdr_valid[i] <= 1'b1;
                    s_hdr[i] <= frame_hdr[src_frame[i][hdr_ptr[i]]];
                end else begin
                    s_hdr_valid[i] <= 1'b0;
                end
                // payload only after its own header has gone
                if (pay_ptr[i] < hdr_ptr[i]) begin
                    s_payload_valid[i] <= 1'b1;
                    s_payload[i] <= frame_beat[src_frame[i][pay_ptr[i]]][beat_ptr[i]];
                end else begin
                    s_payload_valid[i] <= 1'b0;
                end
            end
        end else begin
            s_hdr_valid <= '0;
            s_payload_valid <= '0;
        end
    end

    always @(posedge clk) begin : drive_ready
        logic [31:0] r;
        if (pay_stall) begin
            r = rand_next();
            m_payload_ready <= (r[1:0] != 2'b00);
        end else begin
            m_payload_ready <= 1'b1;
        end
        // header ready held at one level for a random stretch
        if (hdr_stall) begin
            if (hdr_stretch == 0) begin
                r = rand_next();
                hdr_level = r[0];
                hdr_stretch = 1 + int'(r[3:1]);
            end
            m_hdr_ready <= hdr_level;
            hdr_stretch--;
        end else begin
            m_hdr_ready <= 1'b1;
            hdr_stretch = 0;
        end
    end

    always @(posedge clk) begin : compare_outputs
        int f;
        if (!rst) begin
            if (hdr_wait) begin
                if (!m_hdr_valid) begin
                    $display("ERROR: m_hdr_valid dropped before m_hdr was taken");
                    test_errors++;
                    total_errors++;
                end else begin
                    check_hdr("m_hdr", hdr_held, m_hdr);
                end
            end
            hdr_wait = m_hdr_valid && !m_hdr_ready;
            hdr_held = m_hdr;
            if (m_hdr_valid && m_hdr_ready) begin
                if (hdr_idx >= exp_order.size()) begin
                    $display("ERROR: header came out with no frame expected");
                    test_errors++;
                    total_errors++;
                end else begin
                    if (order_check && (beat_frm != hdr_idx || beat_idx != 0)) begin
                        $display("ERROR: header %0d came out before the previous payload ended",
                                 hdr_idx);
                        order_errors++;
                        total_errors++;
                    end
                    check_hdr("m_hdr", frame_hdr[exp_order[hdr_idx]], m_hdr);
                    hdr_idx++;
                end
            end
            if (m_payload_valid && m_payload_ready) begin
                if (beat_frm >= exp_order.size()) begin
                    $display("ERROR: payload beat came out with no frame expected");
                    test_errors++;
                    total_errors++;
                end else begin
                    f = exp_order[beat_frm];
                    if (order_check && beat_frm != hdr_idx - 1) begin
                        $display("ERROR: beat of frame %0d not preceded by its header", beat_frm);
                        order_errors++;
                        total_errors++;
                    end
                    check_beat("m_payload", frame_beat[f][beat_idx], m_payload);
                    beat_idx++;
                    if (beat_idx == frame_len[f]) begin
                        beat_idx = 0;
                        beat_frm++;
                    end
                end
            end
        end
    end

    initial begin : main_flow
        rst = 1'b1;
        s_hdr_valid = '0;
        s_payload_valid = '0;
        m_hdr_ready = 1'b0;
        m_payload_ready = 1'b0;
        for (int i = 0; i < NSRC; i++) begin
            s_hdr[i] = '0;
            s_payload[i] = '0;
            src_seq[i] = 0;
        end
        src_run = 1'b0;
        pay_stall = 1'b0;
        hdr_stall = 1'b0;
        order_check = 1'b0;
        timed_out = 1'b0;
        hdr_wait = 1'b0;
        hdr_level = 1'b1;
        hdr_stretch = 0;
        hdr_idx = 0;
        beat_frm = 0;
        beat_idx = 0;
        last_served = NSRC - 1;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        start_test();

        // reset held for 10 edges, then a few idle cycles
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
            if (c == 9) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_idle();
        end
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        report_test(1, "reset state", test_errors);

        start_test();
        add_frame(2);
        run_frames(1'b0, 1'b0, 1'b0);
        report_test(2, "single frame from source 2", test_errors);

        start_test();
        fill_all_sources();
        run_frames(1'b0, 1'b0, 1'b1);
        report_test(3, "round robin order", test_errors);
        report_test(4, "frames not interleaved", order_errors);

        start_test();
        fill_all_sources();
        run_frames(1'b1, 1'b0, 1'b0);
        report_test(5, "payload back-pressure", test_errors);

        start_test();
        fill_all_sources();
        run_frames(1'b0, 1'b1, 1'b0);
        report_test(6, "header back-pressure", test_errors);

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/arb_mux_pkg.sv
/* Arbitrated mux types */

`default_nettype none

package arb_mux_pkg;

    localparam int S_COUNT    = 4;
    localparam int IDX_WIDTH  = $clog2(S_COUNT);
    localparam int DATA_WIDTH = 8;

    typedef logic [IDX_WIDTH-1:0]  port_idx_t;
    typedef logic [S_COUNT-1:0]    port_mask_t;
    typedef logic [DATA_WIDTH-1:0] payload_data_t;

    // one payload beat, user flags a bad frame
    typedef struct packed {
        payload_data_t data;
        logic          last;
        logic          user;
    } payload_beat_t;

    typedef enum logic [0:0] {
        FRAME_IDLE,
        FRAME_ACTIVE
    } frame_state_t;

endpackage

`default_nettype wire

// File: hdl/eth_hdr_pkg.sv
/* Ethernet and IPv4 header types */

`default_nettype none

package eth_hdr_pkg;

    // ethernet framing
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ether_type_t;

    // ipv4 fields
    typedef logic [31:0] ip_addr_t;
    // length, identification and checksum share this width
    typedef logic [15:0] ip_len_t;

    // whole header as carried beside the payload stream
    typedef struct packed {
        mac_addr_t   eth_dest_mac;
        mac_addr_t   eth_src_mac;
        ether_type_t eth_type;
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        ip_len_t     length;
        ip_len_t     identification;
        ip_len_t     header_checksum;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
    } ip_hdr_t;

endpackage

`default_nettype wire

// File: hdl/frame_select.sv
/* Frame state, header capture and payload select */

`timescale 1ns/100ps
`default_nettype none

module frame_select (
    input  wire                          clk,
    input  wire                          rst,
    // source side
    input  wire arb_mux_pkg::port_mask_t s_hdr_valid,
    output arb_mux_pkg::port_mask_t      s_hdr_ready,
    input  wire eth_hdr_pkg::ip_hdr_t    s_hdr [arb_mux_pkg::S_COUNT],
    input  wire arb_mux_pkg::payload_beat_t s_payload [arb_mux_pkg::S_COUNT],
    input  wire arb_mux_pkg::port_mask_t s_payload_valid,
    output arb_mux_pkg::port_mask_t      s_payload_ready,
    // header output
    output logic                         m_hdr_valid,
    input  wire                          m_hdr_ready,
    output eth_hdr_pkg::ip_hdr_t         m_hdr,
    // arbiter
    output arb_mux_pkg::port_mask_t      request,
    output arb_mux_pkg::port_mask_t      acknowledge,
    input  wire arb_mux_pkg::port_mask_t grant,
    input  wire                          grant_valid,
    input  wire arb_mux_pkg::port_idx_t  grant_index,
    // skid buffer input
    output arb_mux_pkg::payload_beat_t   in_beat,
    output logic                         in_valid,
    input  wire                          in_ready
);

    arb_mux_pkg::frame_state_t state;
    logic                      frame_start;
    logic                      pass_en;
    logic                      beat_xfer;

    assign request = s_hdr_valid;

    // new frame once the header register is free or draining
    assign frame_start = (state == arb_mux_pkg::FRAME_IDLE) && grant_valid &&
                         (!m_hdr_valid || m_hdr_ready);

    // payload only flows once the header is captured
    assign pass_en = in_ready && grant_valid && (state == arb_mux_pkg::FRAME_ACTIVE);

    assign in_beat   = s_payload[grant_index];
    assign in_valid  = s_payload_valid[grant_index] && pass_en;
    assign beat_xfer = in_valid;

    assign s_payload_ready = pass_en ? (arb_mux_pkg::port_mask_t'(1) << grant_index) : '0;

    // end of frame frees the grant
    assign acknowledge = (beat_xfer && in_beat.last) ? grant : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= arb_mux_pkg::FRAME_IDLE;
            s_hdr_ready <= '0;
            m_hdr_valid <= 1'b0;
        end else begin
            // header ready pulses for a single cycle
            s_hdr_ready <= frame_start ? grant : '0;

            if (frame_start) begin
                m_hdr_valid <= 1'b1;
            end else if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end

            if (frame_start) begin
                state <= arb_mux_pkg::FRAME_ACTIVE;
            end else if (beat_xfer && in_beat.last) begin
                state <= arb_mux_pkg::FRAME_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start) begin
            m_hdr <= s_hdr[grant_index];
        end
    end

    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        (m_hdr_valid && !m_hdr_ready) |=> (m_hdr_valid && $stable(m_hdr)));

endmodule

`default_nettype wire

// File: hdl/ip_arb_mux.sv
/* IP frame arbitrated mux */

`timescale 1ns/100ps
`default_nettype none

module ip_arb_mux (
    input  wire                             clk,
    input  wire                             rst,
    // sources
    input  wire arb_mux_pkg::port_mask_t    s_hdr_valid,
    output wire arb_mux_pkg::port_mask_t    s_hdr_ready,
    input  wire eth_hdr_pkg::ip_hdr_t       s_hdr [arb_mux_pkg::S_COUNT],
    input  wire arb_mux_pkg::payload_beat_t s_payload [arb_mux_pkg::S_COUNT],
    input  wire arb_mux_pkg::port_mask_t    s_payload_valid,
    output wire arb_mux_pkg::port_mask_t    s_payload_ready,
    // output frame
    output wire                             m_hdr_valid,
    input  wire                             m_hdr_ready,
    output wire eth_hdr_pkg::ip_hdr_t       m_hdr,
    output wire arb_mux_pkg::payload_beat_t m_payload,
    output wire                             m_payload_valid,
    input  wire                             m_payload_ready
);

    wire arb_mux_pkg::port_mask_t    request;
    wire arb_mux_pkg::port_mask_t    acknowledge;
    wire arb_mux_pkg::port_mask_t    grant;
    wire                             grant_valid;
    wire arb_mux_pkg::port_idx_t     grant_index;
    wire arb_mux_pkg::payload_beat_t in_beat;
    wire                             in_valid;
    wire                             in_ready;

    rr_arbiter arb_inst (
        .clk         (clk),
        .rst         (rst),
        .request     (request),
        .acknowledge (acknowledge),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

    frame_select sel_inst (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_hdr           (s_hdr),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_hdr           (m_hdr),
        .request         (request),
        .acknowledge     (acknowledge),
        .grant           (grant),
        .grant_valid     (grant_valid),
        .grant_index     (grant_index),
        .in_beat         (in_beat),
        .in_valid        (in_valid),
        .in_ready        (in_ready)
    );

    // registered output stage for the payload stream
    payload_skid_buffer skid_inst (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (m_payload),
        .out_valid (m_payload_valid),
        .out_ready (m_payload_ready)
    );

endmodule

`default_nettype wire

// File: hdl/payload_skid_buffer.sv
/* Payload skid buffer */

`timescale 1ns/100ps
`default_nettype none

module payload_skid_buffer (
    input  wire                             clk,
    input  wire                             rst,
    input  wire arb_mux_pkg::payload_beat_t in_beat,
    input  wire                             in_valid,
    output logic                            in_ready,
    output arb_mux_pkg::payload_beat_t      out_beat,
    output logic                            out_valid,
    input  wire                             out_ready
);

    arb_mux_pkg::payload_beat_t temp_beat;
    logic                       temp_valid;
    logic                       out_valid_next;
    logic                       temp_valid_next;
    logic                       in_ready_early;

    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // accept next cycle if the sink drains or both entries are empty
    assign in_ready_early = out_ready || (!temp_valid && !out_valid);

    always_comb begin
        out_valid_next    = out_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;
        if (in_ready) begin
            if (out_ready || !out_valid) begin
                // output free so go straight there
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled so park in temp
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // drain temp into the output
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            in_ready   <= in_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_beat <= in_beat;
        end else if (store_temp_to_out) begin
            out_beat <= temp_beat;
        end
        if (store_in_to_temp) begin
            temp_beat <= in_beat;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)));

endmodule

`default_nettype wire

// File: hdl/rr_arbiter.sv
/* Round-robin arbiter with held grant */

`timescale 1ns/100ps
`default_nettype none

module rr_arbiter (
    input  wire                     clk,
    input  wire                     rst,
    input  wire arb_mux_pkg::port_mask_t request,
    input  wire arb_mux_pkg::port_mask_t acknowledge,
    output arb_mux_pkg::port_mask_t grant,
    output logic                    grant_valid,
    output arb_mux_pkg::port_idx_t  grant_index
);

    // lowest set bit of a request vector
    function automatic arb_mux_pkg::port_idx_t lowest_set(
        input arb_mux_pkg::port_mask_t bits
    );
        arb_mux_pkg::port_idx_t idx;
        idx = '0;
        for (int i = arb_mux_pkg::S_COUNT - 1; i >= 0; i--) begin
            if (bits[i]) begin
                idx = arb_mux_pkg::port_idx_t'(i);
            end
        end
        return idx;
    endfunction

    arb_mux_pkg::port_mask_t req_eff;
    arb_mux_pkg::port_mask_t req_masked;
    arb_mux_pkg::port_mask_t rr_mask;
    arb_mux_pkg::port_mask_t rr_mask_next;
    arb_mux_pkg::port_mask_t grant_next;
    arb_mux_pkg::port_idx_t  pick;
    arb_mux_pkg::port_idx_t  index_next;
    logic                    valid_next;

    // own grant never requests again while held
    assign req_eff    = request & ~grant;
    // sources above the last winner go first
    assign req_masked = req_eff & rr_mask;
    assign pick       = (req_masked != '0) ? lowest_set(req_masked) : lowest_set(req_eff);

    always_comb begin
        grant_next   = grant;
        valid_next   = grant_valid;
        index_next   = grant_index;
        rr_mask_next = rr_mask;
        if (grant_valid) begin
            // release on matching acknowledge
            if ((acknowledge & grant) != '0) begin
                grant_next = '0;
                valid_next = 1'b0;
            end
        end else if (req_eff != '0) begin
            grant_next = arb_mux_pkg::port_mask_t'(1) << pick;
            valid_next = 1'b1;
            index_next = pick;
            for (int i = 0; i < arb_mux_pkg::S_COUNT; i++) begin
                rr_mask_next[i] = (i > pick);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            grant_index <= '0;
            rr_mask     <= '0;
        end else begin
            grant       <= grant_next;
            grant_valid <= valid_next;
            grant_index <= index_next;
            rr_mask     <= rr_mask_next;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && (grant_valid == (grant != '0)));

endmodule

`default_nettype wire

// File: ip_arb_mux.f
hdl/eth_hdr_pkg.sv
hdl/arb_mux_pkg.sv
hdl/rr_arbiter.sv
hdl/frame_select.sv
hdl/payload_skid_buffer.sv
hdl/ip_arb_mux.sv
dv/tb_ip_arb_mux.sv

// File: run_sim.sh
#!/bin/sh
# build and run the arbitrated mux testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_ip_arb_mux \
    -f ip_arb_mux.f \
    -o sim_tb_ip_arb_mux

./obj_dir/sim_tb_ip_arb_mux > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
